// ==== all.f ====
rtl/zports_pkg.sv
rtl/io_strobe.sv
rtl/port_decode.sv
rtl/sys_regs.sv
rtl/sd_port.sv
rtl/read_mux.sv
rtl/zports_top.sv
verif/zports_sva.sv
verif/tb_zports.sv

// ==== rtl/io_strobe.sv ====
// z80 i/o cycle edge detector
// one zclk strobe per read or write cycle

`timescale 1ns/1ps

module io_strobe (
	input  logic                   zclk,
	input  logic                   rst_n,
	input  logic                   iorq_n,
	input  logic                   rd_n,
	input  logic                   wr_n,
	output zports_pkg::io_strobe_t strb
);

	logic wr_act, rd_act;     // bus activity now
	logic wr_act_q, rd_act_q; // activity one cycle ago

	assign wr_act = ~(iorq_n | wr_n);
	assign rd_act = ~(iorq_n | rd_n);

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_act_q <= 1'b0;
			rd_act_q <= 1'b0;
			strb     <= '0;
		end
		else
		begin
			wr_act_q <= wr_act;
			rd_act_q <= rd_act;
			strb.wr  <= wr_act & ~wr_act_q; // rising edge of activity only
			strb.rd  <= rd_act & ~rd_act_q;
		end
	end

endmodule

// ==== rtl/port_decode.sv ====
// port address decode with dos shadow rule
// also porthit, bus drive enable and ay bc1/bdir

`timescale 1ns/1ps

module port_decode (
	input  logic [15:0]           a,
	input  logic                  shadow,
	input  logic                  iorq_n,
	input  logic                  rd_n,
	input  logic                  wr_n,
	output zports_pkg::port_sel_t sel,
	output logic                  porthit,
	output logic                  dataout,
	output logic                  ay_bc1,
	output logic                  ay_bdir
);

	logic [7:0] loa;
	logic       is_fe, is_fd, is_f7, is_bf;
	logic       is_joy, is_mouse, is_sdcfg, is_sddat;
	logic       pre_bc1, pre_bdir;

	assign loa = a[7:0];

	// raw low byte compares
	assign is_fe    = (loa == zports_pkg::port_fe);
	assign is_fd    = (loa == zports_pkg::port_fd);
	assign is_f7    = (loa == zports_pkg::port_f7);
	assign is_bf    = (loa == zports_pkg::port_bf);
	assign is_joy   = (loa == zports_pkg::port_joy);
	assign is_mouse = (loa == zports_pkg::port_mouse);
	assign is_sdcfg = (loa == zports_pkg::port_sdcfg);
	assign is_sddat = (loa == zports_pkg::port_sddat);

	//////////////////////////////////////////////////////////////////////
	// qualified selects

	always_comb
	begin
		sel.fe        = is_fe;
		sel.p7ffd     = is_fd & ~a[15];
		sel.peff7     = is_f7 & ~a[12] & ~shadow;
		sel.bf        = is_bf;
		sel.joy       = is_joy & ~shadow;   // 1f belongs to the fdc in dos
		sel.mouse     = is_mouse;
		sel.sd_cfg_rd = is_sdcfg & ~shadow;
		// in shadow 57 doubles as config when a15 is set
		sel.sd_cfg_wr = (is_sdcfg & ~shadow) | (is_sddat & shadow & a[15]);
		sel.sd_dat_wr = (is_sddat & ~shadow) | (is_sddat & shadow & ~a[15]);
		sel.sd_dat    = is_sddat;
		sel.ext       = is_fd & (a[15:14] == 2'b11);
	end

	// every port this block answers
	assign porthit = is_fe | is_fd | is_mouse | is_sdcfg | is_sddat | is_bf |
	                 (is_joy & ~shadow) | (is_f7 & ~shadow);

	// fffd is read from the ay, not from us
	assign dataout = porthit & ~iorq_n & ~rd_n & ~sel.ext;

	//////////////////////////////////////////////////////////////////////
	// ay chip select

	always_comb
	begin
		pre_bc1  = 1'b0;
		pre_bdir = 1'b0;
		if (is_fd && a[15:14] == 2'b11)      // fffd, register select / read
		begin
			pre_bc1  = 1'b1;
			pre_bdir = 1'b1;
		end
		else if (is_fd && a[15:14] == 2'b10) // bffd, data write
			pre_bdir = 1'b1;
	end

	assign ay_bc1  = pre_bc1 & ~iorq_n & (~rd_n | ~wr_n);
	assign ay_bdir = pre_bdir & ~iorq_n & ~wr_n;

endmodule

// ==== rtl/read_mux.sv ====
// port read data to the z80
// keyboard/tape, kempston joystick and mouse, sd card

`timescale 1ns/1ps

module read_mux (
	input  zports_pkg::port_sel_t sel,
	input  logic [4:0]            keys_in,
	input  logic                  tape_read,
	input  logic [4:0]            kj_in,
	input  logic [7:0]            mus_in,
	input  logic [7:0]            sd_dataout,
	output logic [7:0]            dout
);

	// selects are exclusive, order does not matter
	always_comb
	begin
		if (sel.fe)
			dout = {1'b1, tape_read, 1'b0, keys_in};
		else if (sel.joy)
			dout = {3'b000, kj_in};
		else if (sel.mouse)
			dout = mus_in;
		else if (sel.sd_cfg_rd)
			dout = 8'h00;            // card present, not write protected
		else if (sel.sd_dat)
			dout = sd_dataout;
		else
			dout = zports_pkg::byte_idle;
	end

endmodule

// ==== rtl/sd_port.sv ====
// sd card port, chip select, spi start and data byte

`timescale 1ns/1ps

module sd_port (
	input  logic                   zclk,
	input  logic                   rst_n,
	input  logic [7:0]             din,
	input  logic                   wr_n,
	input  zports_pkg::io_strobe_t strb,
	input  zports_pkg::port_sel_t  sel,
	output logic                   sdcs_n,
	output logic                   sd_start,
	output logic [7:0]             sd_datain
);

	// card deselected out of reset
	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
			sdcs_n <= 1'b1;
		else if (strb.wr && sel.sd_cfg_wr)
			sdcs_n <= din[zports_pkg::sdcfg_cs];
	end

	assign sd_start  = (strb.rd | strb.wr) & sel.sd_dat; // a read also clocks spi
	assign sd_datain = wr_n ? zports_pkg::byte_idle : din; // ff shifted out on reads

endmodule

// ==== rtl/sys_regs.sv ====
// system registers fe, 7ffd, eff7, bf
// border/beeper, pentagon 1m paging with lock rules, shadow enable

`timescale 1ns/1ps

module sys_regs (
	input  logic                   zclk,
	input  logic                   rst_n,
	input  logic [7:0]             din,
	input  logic [15:0]            a,
	input  logic                   dos,
	input  logic [1:0]             rstrom,
	input  zports_pkg::io_strobe_t strb,
	input  zports_pkg::port_sel_t  sel,
	output logic                   shadow,
	output logic [2:0]             border,
	output logic                   beep,
	output zports_pkg::mem_cfg_t   cfg
);

	logic [7:0] p7ffd_r;
	logic [7:0] peff7_r;
	logic       shadow_en;  // bf bit 0
	logic       romrw_en;   // bf bit 1
	logic [1:0] rom_sync;   // reset release sync for the rom bit
	logic       block1m;
	logic       block7ffd;

	assign shadow    = dos | shadow_en;
	assign block1m   = peff7_r[zports_pkg::eff7_block1m];
	assign block7ffd = p7ffd_r[zports_pkg::p7ffd_lock] & block1m;

	// fe: border + beeper
	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			border <= 3'd0;
			beep   <= 1'b0;
		end
		else if (strb.wr && sel.fe)
		begin
			border <= din[2:0];
			beep   <= din[zports_pkg::fe_ear] ^ din[zports_pkg::fe_mic]; // shared pin
		end
	end

	//////////////////////////////////////////////////////////////////////
	// paging

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
			rom_sync <= 2'b11;
		else
			rom_sync <= {rom_sync[0], 1'b0};
	end

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
			p7ffd_r <= 8'h00;
		else
		begin
			if (strb.wr && sel.p7ffd && !block7ffd) // locked in 48k mode
				p7ffd_r <= din;
			if (rom_sync[1])
				p7ffd_r[zports_pkg::p7ffd_rom] <= rstrom[0]; // boot rom choice
		end
	end

	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
			peff7_r <= 8'h00;
		else if (strb.wr && sel.peff7)
			peff7_r <= din;
	end

	// bf: shadow enable, rom write enable
	always_ff @(posedge zclk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			shadow_en <= 1'b0;
			romrw_en  <= 1'b0;
		end
		else if (strb.wr && sel.bf)
		begin
			shadow_en <= din[zports_pkg::bf_shadow];
			romrw_en  <= din[zports_pkg::bf_romrw];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// outputs, 128k view when 1m is blocked

	always_comb
	begin
		cfg.p7ffd    = {(block1m ? 3'b000 : p7ffd_r[7:5]), p7ffd_r[4:0]};
		cfg.peff7    = block1m ? {peff7_r[7], 1'b0, peff7_r[5:4], 3'b000, peff7_r[0]}
		                       : peff7_r;
		cfg.page     = {p7ffd_r[7:5], p7ffd_r[2:0]}; // full 1m page
		cfg.rom      = p7ffd_r[zports_pkg::p7ffd_rom];
		cfg.ram0_0   = peff7_r[zports_pkg::eff7_ram0];
		cfg.on_1m    = ~block1m;
		cfg.romrw_en = romrw_en;
	end

endmodule

// ==== rtl/zports_pkg.sv ====
// z80 port block shared definitions
// port addresses, register bit positions, bus-side structs

package zports_pkg;

	// low address byte of each kept port
	localparam logic [7:0] port_fe    = 8'hfe; // keyboard, tape, border
	localparam logic [7:0] port_fd    = 8'hfd; // 7ffd paging, fffd/bffd ay
	localparam logic [7:0] port_f7    = 8'hf7; // eff7
	localparam logic [7:0] port_bf    = 8'hbf; // shadow / rom write config
	localparam logic [7:0] port_joy   = 8'h1f; // kempston
	localparam logic [7:0] port_mouse = 8'hdf; // kempston mouse
	localparam logic [7:0] port_sdcfg = 8'h77; // sd card config
	localparam logic [7:0] port_sddat = 8'h57; // sd card spi data

	localparam logic [7:0] byte_idle  = 8'hff; // floating bus value

	// register bit positions
	localparam int fe_mic       = 3; // tape out
	localparam int fe_ear       = 4; // beeper
	localparam int p7ffd_rom    = 4;
	localparam int p7ffd_lock   = 5; // 48k lock
	localparam int eff7_block1m = 2;
	localparam int eff7_ram0    = 3;
	localparam int bf_shadow    = 0;
	localparam int bf_romrw     = 1;
	localparam int sdcfg_cs     = 1;

	// port selects, address and shadow already applied
	typedef struct packed {
		logic fe;
		logic p7ffd;
		logic peff7;
		logic bf;
		logic joy;
		logic mouse;
		logic sd_cfg_rd;
		logic sd_cfg_wr;
		logic sd_dat_wr;
		logic sd_dat;
		logic ext;       // fffd, data comes from the ay chip
	} port_sel_t;

	typedef struct packed {
		logic wr;
		logic rd;
	} io_strobe_t;

	typedef struct packed {
		logic [7:0] p7ffd;
		logic [7:0] peff7;
		logic [5:0] page;
		logic       rom;
		logic       ram0_0;
		logic       on_1m;
		logic       romrw_en;
	} mem_cfg_t;

endpackage

// ==== rtl/zports_top.sv ====
// z80 i/o port block top
// strobes, decode, registers, sd card and read mux

`timescale 1ns/1ps

module zports_top (
	input  logic        zclk,
	input  logic        rst_n,
	input  logic [7:0]  din,
	output logic [7:0]  dout,
	output logic        dataout,
	input  logic [15:0] a,
	input  logic        iorq_n,
	input  logic        rd_n,
	input  logic        wr_n,
	output logic        porthit,
	input  logic [4:0]  keys_in,
	input  logic [7:0]  mus_in,
	input  logic [4:0]  kj_in,
	output logic [2:0]  border,
	output logic        beep,
	input  logic        dos,
	output logic        ay_bdir,
	output logic        ay_bc1,
	output logic [7:0]  p7ffd,
	output logic [7:0]  peff7,
	input  logic [1:0]  rstrom,
	input  logic        tape_read,
	output logic        sdcs_n,
	output logic        sd_start,
	output logic [7:0]  sd_datain,
	input  logic [7:0]  sd_dataout,
	output logic        romrw_en,
	output logic        pent1m_ram0_0,
	output logic        pent1m_1m_on,
	output logic [5:0]  pent1m_page,
	output logic        pent1m_rom
);

	zports_pkg::io_strobe_t strb;
	zports_pkg::port_sel_t  sel;
	zports_pkg::mem_cfg_t   cfg;
	logic                   shadow;

	io_strobe u_strobe (.zclk, .rst_n, .iorq_n, .rd_n, .wr_n, .strb);

	port_decode u_decode (.a, .shadow, .iorq_n, .rd_n, .wr_n, .sel, .porthit,
	                      .dataout, .ay_bc1, .ay_bdir);

	sys_regs u_regs (.zclk, .rst_n, .din, .a, .dos, .rstrom, .strb, .sel, .shadow,
	                 .border, .beep, .cfg);

	sd_port u_sd (.zclk, .rst_n, .din, .wr_n, .strb, .sel, .sdcs_n, .sd_start, .sd_datain);

	read_mux u_rmux (.sel, .keys_in, .tape_read, .kj_in, .mus_in, .sd_dataout, .dout);

	// paging fields out to the memory pager
	assign p7ffd         = cfg.p7ffd;
	assign peff7         = cfg.peff7;
	assign pent1m_page   = cfg.page;
	assign pent1m_rom    = cfg.rom;
	assign pent1m_ram0_0 = cfg.ram0_0;
	assign pent1m_1m_on  = cfg.on_1m;
	assign romrw_en      = cfg.romrw_en;

endmodule

// ==== verif/tb_zports.sv ====
// testbench for the z80 i/o port block
// lfsr driven bus cycles checked against a reference model

`timescale 1ns/1ps

module tb_zports;

	localparam int n_cycles = 400; // bus cycles per run
	localparam int t_clk    = 100; // ns

	logic        zclk, rst_n, iorq_n, rd_n, wr_n, dos, tape_read;
	logic [15:0] a;
	logic [7:0]  din, mus_in, sd_dataout;
	logic [4:0]  keys_in, kj_in;
	logic [1:0]  rstrom;
	wire  [7:0]  dout, p7ffd, peff7, sd_datain;
	wire  [5:0]  pent1m_page;
	wire  [2:0]  border;
	wire         dataout, porthit, beep, ay_bdir, ay_bc1, sdcs_n, sd_start, romrw_en;
	wire         pent1m_ram0_0, pent1m_1m_on, pent1m_rom;

	logic [31:0] lfsr;
	logic [7:0]  m_p7ffd, m_eff7;   // model registers
	logic [2:0]  m_border;
	logic        m_beep, m_shadow_en, m_romrw, m_sdcs_n;
	int          byte_errs, bit_errs, cfg_errs;

	zports_top uut (.*);

	initial
	begin
		zclk = 1'b1; // first falling edge half a period in
		forever #(t_clk / 2) zclk = ~zclk;
	end

	// 400 clocks per bus cycle plus margin
	initial
	begin
		#((n_cycles * 400 + 1000) * t_clk);
		$display("watchdog expired before all bus cycles completed");
		$display("tests failed");
		$finish;
	end

	//////////////////////////////////////////////////////////////////////
	// random source and compare tasks

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32 22 2 1
	endfunction

	task automatic rand_bits(input int n, output logic [31:0] v);
		v = '0;
		repeat (n)
		begin
			lfsr = lfsr_step(lfsr);
			v    = {v[30:0], lfsr[0]}; // one step per bit
		end
	endtask

	task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
		if (got !== exp)
		begin
			byte_errs++;
			$display("Fail %0t %s: got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp)
		begin
			bit_errs++;
			$display("Fail %0t %s: got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic check_cfg(input zports_pkg::mem_cfg_t got, input zports_pkg::mem_cfg_t exp);
		if (got !== exp)
		begin
			cfg_errs++;
			$display("Fail %0t mem_cfg: got %h expected %h", $time, got, exp);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// reference model

	function automatic zports_pkg::mem_cfg_t exp_cfg();
		zports_pkg::mem_cfg_t c;
		logic                 blk;
		blk        = m_eff7[2];                        // 1m blocked
		c.p7ffd    = blk ? (m_p7ffd & 8'h1f) : m_p7ffd; // 128k view
		c.peff7    = blk ? (m_eff7 & 8'hb1) : m_eff7;   // bits 7 5 4 0 only
		c.page     = {m_p7ffd[7:5], m_p7ffd[2:0]};
		c.rom      = m_p7ffd[4];
		c.ram0_0   = m_eff7[3];
		c.on_1m    = ~blk;
		c.romrw_en = m_romrw;
		return c;
	endfunction

	function automatic logic [7:0] exp_dout(input logic [7:0] lo, input logic sh);
		if (lo == 8'hfe)
			return {1'b1, tape_read, 1'b0, keys_in};
		else if (lo == 8'h1f && !sh)
			return {3'b000, kj_in};
		else if (lo == 8'hdf)
			return mus_in;
		else if (lo == 8'h77 && !sh)
			return 8'h00;                  // sd config status
		else if (lo == 8'h57)
			return sd_dataout;
		return 8'hff;                      // unmapped
	endfunction

	task automatic apply_write(input logic [15:0] addr, input logic [7:0] data, input logic sh);
		case (addr[7:0])
			8'hfe:
			begin
				m_border = data[2:0];
				m_beep   = data[4] ^ data[3];
			end
			8'hfd: if (!addr[15] && !(m_p7ffd[5] && m_eff7[2])) m_p7ffd = data; // lock
			8'hf7: if (!addr[12] && !sh) m_eff7 = data;
			8'hbf:
			begin
				m_shadow_en = data[0];
				m_romrw     = data[1];
			end
			8'h77: if (!sh) m_sdcs_n = data[1];
			8'h57: if (sh && addr[15]) m_sdcs_n = data[1]; // config alias in shadow
			default: ;
		endcase
	endtask

	task automatic check_regs();
		zports_pkg::mem_cfg_t got;
		got = {p7ffd, peff7, pent1m_page, pent1m_rom, pent1m_ram0_0, pent1m_1m_on, romrw_en};
		check_byte("border", {5'b0, border}, {5'b0, m_border});
		check_bit("beep", beep, m_beep);
		check_bit("sdcs_n", sdcs_n, m_sdcs_n);
		check_cfg(got, exp_cfg());
	endtask

	// async reset held for 3 clocks, model back to its reset values
	task automatic reset_dut(input logic [1:0] rom_cfg);
		rst_n       = 1'b0;
		rstrom      = rom_cfg;
		m_p7ffd     = {3'b000, rom_cfg[0], 4'h0}; // boot rom choice
		m_eff7      = 8'h00;
		m_border    = 3'd0;
		m_beep      = 1'b0;
		m_shadow_en = 1'b0;
		m_romrw     = 1'b0;
		m_sdcs_n    = 1'b1;
		repeat (3) @(negedge zclk);
		rst_n = 1'b1;
		repeat (2) @(negedge zclk); // rom bit reload
		check_regs();
	endtask

	// one z80 i/o cycle, 3 clocks active then 1 idle, entered on a falling edge
	task automatic bus_cycle(input logic is_wr, input logic [15:0] addr, input logic [7:0] data);
		logic [7:0] lo;
		logic       sh, hit, ext;
		int         starts;
		lo     = addr[7:0];
		sh     = dos | m_shadow_en;
		ext    = (lo == 8'hfd) && (addr[15:14] == 2'b11);     // fffd
		hit    = (lo inside {8'hfe, 8'hfd, 8'hdf, 8'h77, 8'h57, 8'hbf}) ||
		         (!sh && (lo == 8'h1f || lo == 8'hf7));
		starts = 0;
		a      = addr;
		din    = data;
		iorq_n = 1'b0;
		rd_n   = is_wr;
		wr_n   = !is_wr;
		repeat (3)
		begin
			#20; // clear of both edges
			check_bit("porthit", porthit, hit);
			check_bit("dataout", dataout, hit && !is_wr && !ext);
			check_bit("ay_bc1", ay_bc1, ext);                 // rd or wr is held
			check_bit("ay_bdir", ay_bdir, is_wr && lo == 8'hfd && addr[15]);
			check_byte("sd_datain", sd_datain, is_wr ? data : 8'hff);
			check_byte("dout", dout, exp_dout(lo, sh));
			if (sd_start)
				starts++;
			@(negedge zclk);
		end
		iorq_n = 1'b1;
		rd_n   = 1'b1;
		wr_n   = 1'b1;
		check_byte("sd_start pulses", 8'(starts), {7'b0, lo == 8'h57});
		if (is_wr)
			apply_write(addr, data, sh);
		#20;
		check_regs();
		@(negedge zclk);
	endtask

	//////////////////////////////////////////////////////////////////////
	// main sequence

	initial
	begin
		logic [31:0] r, p;
		logic [7:0]  lo;
		logic [7:0]  port_list [8];
		int          total;
		port_list = '{8'hfe, 8'hfd, 8'hf7, 8'hbf, 8'h1f, 8'hdf, 8'h77, 8'h57};
		lfsr      = 32'hb32f6c48;
		byte_errs = 0;
		bit_errs  = 0;
		cfg_errs  = 0;
		rst_n     = 1'b0;
		iorq_n    = 1'b1;
		rd_n      = 1'b1;
		wr_n      = 1'b1;
		a         = 16'h0000;
		din       = 8'h00;
		dos       = 1'b0;
		tape_read = 1'b0;
		keys_in   = 5'h00;
		kj_in     = 5'h00;
		mus_in    = 8'h00;
		sd_dataout = 8'h00;
		rand_bits(2, r);
		reset_dut(r[1:0]);
		for (int i = 0; i < n_cycles; i++)
		begin
			if (i == n_cycles / 3)
				dos = 1'b1;     // dos rom paged in, shadow forced
			else if (i == 2 * n_cycles / 3)
				dos = 1'b0;
			if (i == n_cycles / 2)
				reset_dut({rstrom[1], ~rstrom[0]}); // other boot rom
			rand_bits(32, r);
			rand_bits(27, p);
			lo         = (r[4:3] == 2'b00) ? r[23:16] : port_list[r[7:5]]; // mostly kept ports
			keys_in    = p[4:0];
			kj_in      = p[9:5];
			mus_in     = p[17:10];
			sd_dataout = p[25:18];
			tape_read  = p[26];
			bus_cycle(r[2], {r[31:24], lo}, r[15:8]);
		end
		total = byte_errs + bit_errs + cfg_errs;
		$display("errors: byte %0d, bit %0d, mem_cfg %0d", byte_errs, bit_errs, cfg_errs);
		if (total == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// ==== verif/zports_sva.sv ====
// assertions on the system register block
// strobe width, 7ffd lock, register values in reset

`timescale 1ns/1ps

module zports_sva (
	input logic                   zclk,
	input logic                   rst_n,
	input zports_pkg::io_strobe_t strb,
	input logic [7:0]             p7ffd_r,
	input logic [7:0]             peff7_r,
	input logic [2:0]             border,
	input logic                   shadow_en
);

	logic locked;

	assign locked = p7ffd_r[zports_pkg::p7ffd_lock] & peff7_r[zports_pkg::eff7_block1m];

	strb_wr_single: assert property (@(posedge zclk) disable iff (!rst_n) strb.wr |=> !strb.wr)
		else $error("write strobe held past one cycle");
	strb_rd_single: assert property (@(posedge zclk) disable iff (!rst_n) strb.rd |=> !strb.rd)
		else $error("read strobe held past one cycle");

	// 48k lock freezes 7ffd
	p7ffd_frozen: assert property (@(posedge zclk) disable iff (!rst_n) locked |=> $stable(p7ffd_r))
		else $error("7ffd changed while locked");

	regs_in_reset: assert property (@(posedge zclk)
		!rst_n |-> (p7ffd_r == 8'h00 && peff7_r == 8'h00 && border == 3'd0 && !shadow_en))
		else $error("register not cleared in reset");

endmodule

bind sys_regs zports_sva u_sva (.zclk, .rst_n, .strb, .p7ffd_r, .peff7_r, .border, .shadow_en);
